// ==== common/life_pkg.sv ====
// life core shared definitions
// types, bridge map, colours and the seed pattern

package life_pkg;

    // pixel or line counter value
    typedef logic [11:0] coord_t;
    typedef logic [23:0] rgb_t;
    typedef logic [31:0] bridge_addr_t;
    typedef logic [31:0] bridge_data_t;
    // rate increment added to the tick accumulator each clock
    typedef logic [31:0] gen_speed_t;

    // registered video bundle
    typedef struct packed {
        rgb_t rgb;
        logic de;
        logic skip;
        logic hs;
        logic vs;
    } video_out_t;

    localparam bridge_addr_t GEN_SPEED_ADDR  = 32'h0010_0000;
    localparam gen_speed_t   GEN_SPEED_RESET = 32'd1;

    // start button bit in the controller key map
    localparam int KEY_START = 15;

    localparam rgb_t RGB_ALIVE = 24'hFF_FFFF;

    // seed rows, bit n is column offset n
    localparam logic [4:0] SEED_ROW0 = 5'b10011;
    localparam logic [4:0] SEED_ROW1 = 5'b10001;
    localparam logic [4:0] SEED_ROW2 = 5'b11001;

endpackage

// ==== life_core_top.f ====
common/life_pkg.sv
source/video_timing.sv
source/life_regs.sv
source/generation_timer.sv
life_grid/life_cell.sv
life_grid/life_grid.sv
source/cell_renderer.sv
source/life_core_top.sv
verif/life_core_tb.sv

// ==== life_grid/life_cell.sv ====
// single life cell
// counts live neighbours and applies the survival rule on each tick

`timescale 1ns/1ps

module life_cell (
    input  logic       clk_74a,
    input  logic       reset_n,
    input  logic [7:0] neighbours,
    input  logic       tick,
    input  logic       load,
    input  logic       seed_value,
    output logic       state
);

    logic [3:0] population;
    logic       next_state;

    always_comb begin
        population = '0;
        for (int i = 0; i < 8; i++) begin
            population = population + 4'(neighbours[i]);
        end
    end

    // birth on three, survival on two or three
    assign next_state = (population == 4'd3) || ((population == 4'd2) && state);

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            state <= seed_value;
        end else if (load) begin
            // restart takes priority over a generation step
            state <= seed_value;
        end else if (tick) begin
            state <= next_state;
        end
    end

endmodule

// ==== life_grid/life_grid.sv ====
// toroidal life grid
// builds the seed from the package rows and wires every cell to its
// eight wrapped neighbours

`timescale 1ns/1ps

module life_grid import life_pkg::*; #(
    parameter int GRID_W = 64,
    parameter int GRID_H = 48
) (
    input  logic                       clk_74a,
    input  logic                       reset_n,
    input  logic                       tick,
    input  logic                       restart,
    output logic [GRID_W*GRID_H-1:0]   cells
);

    localparam int N_CELLS = GRID_W * GRID_H;

    // seed placed with its top-left cell near the grid centre
    function automatic logic [N_CELLS-1:0] build_seed();
        logic [N_CELLS-1:0] seed;
        logic [4:0]         row_bits;
        int                 row;
        int                 col;
        seed = '0;
        for (int r = 0; r < 3; r++) begin
            case (r)
                0:       row_bits = SEED_ROW0;
                1:       row_bits = SEED_ROW1;
                default: row_bits = SEED_ROW2;
            endcase
            row = (GRID_H / 2 - 2 + r) % GRID_H;
            for (int c = 0; c < 5; c++) begin
                col = (GRID_W / 2 - 2 + c) % GRID_W;
                seed[row * GRID_W + col] = row_bits[c];
            end
        end
        return seed;
    endfunction

    localparam logic [N_CELLS-1:0] SEED = build_seed();

    ////////////////////////////////////////////////////////////
    // cell array
    ////////////////////////////////////////////////////////////

    for (genvar r = 0; r < GRID_H; r++) begin : g_row
        // wrapped row above and below
        localparam int RN = (r + GRID_H - 1) % GRID_H;
        localparam int RS = (r + 1) % GRID_H;

        for (genvar c = 0; c < GRID_W; c++) begin : g_col
            localparam int CW = (c + GRID_W - 1) % GRID_W;
            localparam int CE = (c + 1) % GRID_W;

            logic [7:0] neighbours;

            assign neighbours = {
                cells[RN * GRID_W + CW], cells[RN * GRID_W + c], cells[RN * GRID_W + CE],
                cells[r  * GRID_W + CW],                         cells[r  * GRID_W + CE],
                cells[RS * GRID_W + CW], cells[RS * GRID_W + c], cells[RS * GRID_W + CE]
            };

            life_cell u_cell (
                .clk_74a    (clk_74a),
                .reset_n    (reset_n),
                .neighbours (neighbours),
                .tick       (tick),
                .load       (restart),
                .seed_value (SEED[r * GRID_W + c]),
                .state      (cells[r * GRID_W + c])
            );
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile the life core testbench with Verilator and run it
# the run fails when the log holds the fail message

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module life_core_tb -f life_core_top.f -o life_core_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/life_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
    exit 1
fi
exit 0

// ==== source/cell_renderer.sv ====
// cell renderer
// picks the cell under the visible pixel and registers colour
// and syncs together as one video bundle

`timescale 1ns/1ps

module cell_renderer import life_pkg::*; #(
    parameter int GRID_W  = 64,
    parameter int GRID_H  = 48,
    parameter int CELL_PX = 10
) (
    input  logic                     clk_74a,
    input  logic                     reset_n,
    input  coord_t                   x,
    input  coord_t                   y,
    input  logic                     active,
    input  logic                     line_start,
    input  logic                     frame_start,
    input  logic [GRID_W*GRID_H-1:0] cells,
    output video_out_t               video
);

    localparam int IDX_W = $clog2(GRID_W * GRID_H);

    coord_t           col;
    coord_t           row;
    logic [IDX_W-1:0] cell_idx;
    logic             alive;

    assign col = coord_t'(x / CELL_PX);
    assign row = coord_t'(y / CELL_PX);

    // outside the window the position is meaningless
    assign cell_idx = active ? IDX_W'(row * GRID_W + col) : '0;
    assign alive    = active && cells[cell_idx];

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            video <= '0;
        end else begin
            video.rgb  <= alive ? RGB_ALIVE : '0;
            video.de   <= active;
            video.skip <= 1'b0;
            video.hs   <= line_start;
            video.vs   <= frame_start;
        end
    end

endmodule

// ==== source/generation_timer.sv ====
// generation rate accumulator
// adds the speed setting every clock and issues one tick per
// threshold crossing, frozen while the host menu is open

`timescale 1ns/1ps

module generation_timer import life_pkg::*; #(
    parameter int unsigned GEN_THRESHOLD = 25_000_000
) (
    input  logic       clk_74a,
    input  logic       reset_n,
    input  gen_speed_t gen_speed,
    input  logic       in_menu,
    output logic       tick
);

    // one spare bit so a large speed cannot wrap the sum
    logic [$bits(gen_speed_t):0] accum;

    assign tick = !in_menu && (accum >= GEN_THRESHOLD);

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            accum <= '0;
        end else if (tick) begin
            accum <= '0;
        end else if (!in_menu) begin
            accum <= accum + gen_speed;
        end
    end

endmodule

// ==== source/life_core_top.sv ====
// life display core top level
// bridge speed register, generation timer, cell grid and video
// path, plus the start-button restart detector

`timescale 1ns/1ps

module life_core_top import life_pkg::*; #(
    parameter int          GRID_W        = 64,
    parameter int          GRID_H        = 48,
    parameter int          CELL_PX       = 10,
    parameter int          H_BPORCH      = 160,
    parameter int          H_ACTIVE      = 640,
    parameter int          H_TOTAL       = 800,
    parameter int          V_BPORCH      = 20,
    parameter int          V_ACTIVE      = 480,
    parameter int          V_TOTAL       = 500,
    parameter int unsigned GEN_THRESHOLD = 25_000_000
) (
    input  logic         clk_74a,
    input  logic         reset_n,
    input  bridge_addr_t bridge_addr,
    input  logic         bridge_rd,
    input  logic         bridge_wr,
    input  bridge_data_t bridge_wr_data,
    input  logic [15:0]  cont1_key,
    input  logic         osnotify_inmenu,
    output bridge_data_t bridge_rd_data,
    output rgb_t         video_rgb,
    output logic         video_de,
    output logic         video_skip,
    output logic         video_hs,
    output logic         video_vs
);

    gen_speed_t               gen_speed;
    logic                     tick;
    logic                     restart;
    logic                     start_prev;
    logic [GRID_W*GRID_H-1:0] cells;
    coord_t                   x;
    coord_t                   y;
    logic                     active;
    logic                     line_start;
    logic                     frame_start;
    video_out_t               video;

    ////////////////////////////////////////////////////////////
    // start button edge
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            start_prev <= 1'b0;
        end else begin
            start_prev <= cont1_key[KEY_START];
        end
    end

    assign restart = cont1_key[KEY_START] && !start_prev;

    ////////////////////////////////////////////////////////////
    // blocks
    ////////////////////////////////////////////////////////////

    // bridge_rd is not needed, reads only follow the address
    life_regs u_regs (
        .clk_74a        (clk_74a),
        .reset_n        (reset_n),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd_data (bridge_rd_data),
        .gen_speed      (gen_speed)
    );

    generation_timer #(.GEN_THRESHOLD(GEN_THRESHOLD)) u_timer (
        .clk_74a   (clk_74a),
        .reset_n   (reset_n),
        .gen_speed (gen_speed),
        .in_menu   (osnotify_inmenu),
        .tick      (tick)
    );

    life_grid #(.GRID_W(GRID_W), .GRID_H(GRID_H)) u_grid (
        .clk_74a (clk_74a),
        .reset_n (reset_n),
        .tick    (tick),
        .restart (restart),
        .cells   (cells)
    );

    video_timing #(
        .H_BPORCH (H_BPORCH),
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .V_BPORCH (V_BPORCH),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL)
    ) u_timing (
        .clk_74a     (clk_74a),
        .reset_n     (reset_n),
        .x           (x),
        .y           (y),
        .active      (active),
        .line_start  (line_start),
        .frame_start (frame_start)
    );

    cell_renderer #(.GRID_W(GRID_W), .GRID_H(GRID_H), .CELL_PX(CELL_PX)) u_render (
        .clk_74a     (clk_74a),
        .reset_n     (reset_n),
        .x           (x),
        .y           (y),
        .active      (active),
        .line_start  (line_start),
        .frame_start (frame_start),
        .cells       (cells),
        .video       (video)
    );

    // unpack the registered bundle onto the video port
    assign video_rgb  = video.rgb;
    assign video_de   = video.de;
    assign video_skip = video.skip;
    assign video_hs   = video.hs;
    assign video_vs   = video.vs;

endmodule

// ==== source/life_regs.sv ====
// generation speed register on the host bridge
// one write-decoded register and the bridge read mux

`timescale 1ns/1ps

module life_regs import life_pkg::*; (
    input  logic         clk_74a,
    input  logic         reset_n,
    input  bridge_addr_t bridge_addr,
    input  logic         bridge_wr,
    input  bridge_data_t bridge_wr_data,
    output bridge_data_t bridge_rd_data,
    output gen_speed_t   gen_speed
);

    gen_speed_t speed_q;
    logic       speed_wr;

    ////////////////////////////////////////////////////////////
    // write side
    ////////////////////////////////////////////////////////////

    assign speed_wr = bridge_wr && (bridge_addr == GEN_SPEED_ADDR);

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            speed_q <= GEN_SPEED_RESET;
        end else if (speed_wr) begin
            speed_q <= gen_speed_t'(bridge_wr_data);
        end
    end

    assign gen_speed = speed_q;

    ////////////////////////////////////////////////////////////
    // read side
    ////////////////////////////////////////////////////////////

    // reads have no side effect, so the mux follows the address alone
    always_comb begin
        if (bridge_addr == GEN_SPEED_ADDR) begin
            bridge_rd_data = bridge_data_t'(speed_q);
        end else begin
            bridge_rd_data = '0;
        end
    end

endmodule

// ==== source/video_timing.sv ====
// video timing generator
// raw pixel and line counters, visible position, active window
// and the sync position decodes

`timescale 1ns/1ps

module video_timing import life_pkg::*; #(
    parameter int H_BPORCH = 160,
    parameter int H_ACTIVE = 640,
    parameter int H_TOTAL  = 800,
    parameter int V_BPORCH = 20,
    parameter int V_ACTIVE = 480,
    parameter int V_TOTAL  = 500
) (
    input  logic   clk_74a,
    input  logic   reset_n,
    output coord_t x,
    output coord_t y,
    output logic   active,
    output logic   line_start,
    output logic   frame_start
);

    coord_t h_count;
    coord_t v_count;

    // counters advance every clock, one pixel per clock
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_count == coord_t'(H_TOTAL - 1)) begin
            h_count <= '0;
            if (v_count == coord_t'(V_TOTAL - 1)) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 1'b1;
            end
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    // visible position relative to the back porch
    assign x = coord_t'(h_count - H_BPORCH);
    assign y = coord_t'(v_count - V_BPORCH);

    assign active = (h_count >= coord_t'(H_BPORCH)) &&
                    (h_count <  coord_t'(H_BPORCH + H_ACTIVE)) &&
                    (v_count >= coord_t'(V_BPORCH)) &&
                    (v_count <  coord_t'(V_BPORCH + V_ACTIVE));

    // hs sits a few clocks after vs so the two never coincide
    assign line_start  = (h_count == coord_t'(3));
    assign frame_start = (h_count == '0) && (v_count == '0);

endmodule

// ==== verif/life_core_tb.sv ====
// life core testbench
// drives bridge, start button and menu flag, and checks the video
// frames against a reference Life model on a small torus

`timescale 1ns/1ps

module life_core_tb import life_pkg::*; ();

    localparam int GW = 8;
    localparam int GH = 6;
    localparam int CPX = 2;
    localparam int FW = GW * CPX;
    localparam int FH = GH * CPX;
    localparam int MAX_GEN = 40;
    localparam int LIMIT = 2000;

    logic         clk_74a;
    logic         reset_n;
    bridge_addr_t bridge_addr;
    logic         bridge_rd;
    logic         bridge_wr;
    bridge_data_t bridge_wr_data;
    logic [15:0]  cont1_key;
    logic         osnotify_inmenu;
    bridge_data_t bridge_rd_data;
    rgb_t         video_rgb;
    logic         video_de;
    logic         video_skip;
    logic         video_hs;
    logic         video_vs;

    bit   model [0:MAX_GEN][0:GH-1][0:GW-1];
    rgb_t frame [0:FW*FH-1];
    rgb_t prev_frame [0:FW*FH-1];
    int   errors;
    int   test_start;
    int   tests_run;
    int   tests_failed;
    int   cap_clocks;
    int   cap_hs;
    int   cap_de;

    life_core_top #(
        .GRID_W(GW), .GRID_H(GH), .CELL_PX(CPX),
        .H_BPORCH(4), .H_ACTIVE(16), .H_TOTAL(24),
        .V_BPORCH(2), .V_ACTIVE(12), .V_TOTAL(16),
        .GEN_THRESHOLD(1000)
    ) uut (.*);

    initial clk_74a = 1'b0;
    always #50 clk_74a = ~clk_74a;

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    task automatic build_model();
        bit [4:0] seed_rows [0:2];
        int       n;
        seed_rows = '{5'b10011, 5'b10001, 5'b11001};
        model = '{default: 1'b0};
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 5; c++) begin
                model[0][GH/2-2+r][GW/2-2+c] = seed_rows[r][c];
            end
        end
        // birth on three neighbours, survival on two or three
        for (int g = 0; g < MAX_GEN; g++) begin
            for (int r = 0; r < GH; r++) begin
                for (int c = 0; c < GW; c++) begin
                    n = 0;
                    for (int dr = -1; dr <= 1; dr++) begin
                        for (int dc = -1; dc <= 1; dc++) begin
                            if (dr != 0 || dc != 0)
                                n += model[g][(r+dr+GH)%GH][(c+dc+GW)%GW];
                        end
                    end
                    model[g+1][r][c] = (n == 3) || (n == 2 && model[g][r][c]);
                end
            end
        end
    endtask

    function automatic rgb_t expected_px(int k, int i);
        return model[k][(i/FW)/CPX][(i%FW)/CPX] ? 24'hFF_FFFF : 24'h0;
    endfunction

    // first generation in [lo, hi] that the captured frame shows, or -1
    function automatic int find_gen(int lo, int hi);
        bit same;
        for (int k = lo; k <= hi && k <= MAX_GEN; k++) begin
            same = 1'b1;
            for (int i = 0; i < FW*FH; i++) begin
                if (frame[i] != expected_px(k, i)) same = 1'b0;
            end
            if (same) return k;
        end
        return -1;
    endfunction

    function automatic bit frame_matches_prev();
        bit same;
        same = 1'b1;
        for (int i = 0; i < FW*FH; i++) begin
            if (frame[i] != prev_frame[i]) same = 1'b0;
        end
        return same;
    endfunction

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic expect_eq(string name, logic [31:0] got, logic [31:0] exp);
        assert (got == exp) else begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic abort_run(string what);
        $display("timeout: no %s within %0d clocks", what, LIMIT);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (errors == test_start) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errors - test_start);
            tests_failed++;
        end
        test_start = errors;
    endtask

    task automatic bridge_read(bridge_addr_t addr, output bridge_data_t data);
        @(negedge clk_74a);
        bridge_addr = addr;
        bridge_rd = 1'b1;
        @(negedge clk_74a);
        data = bridge_rd_data;
        bridge_rd = 1'b0;
    endtask

    task automatic bridge_write(bridge_addr_t addr, bridge_data_t data);
        @(negedge clk_74a);
        bridge_addr = addr;
        bridge_wr_data = data;
        bridge_wr = 1'b1;
        @(negedge clk_74a);
        bridge_wr = 1'b0;
    endtask

    // records one frame from a vs pulse up to the next one
    // a capture that follows another starts on the vs that ended it
    task automatic capture_frame();
        int n;
        int px;
        n = 0;
        while (!video_vs && n < LIMIT) begin
            @(negedge clk_74a);
            n++;
        end
        if (!video_vs) abort_run("video_vs pulse");
        n = 0;
        px = 0;
        cap_hs = 0;
        do begin
            @(negedge clk_74a);
            n++;
            expect_eq("video_skip", video_skip, 0);
            if (!video_vs && video_hs) cap_hs++;
            if (!video_vs && video_de) begin
                if (px < FW*FH) frame[px] = video_rgb;
                px++;
            end
        end while (!video_vs && n < LIMIT);
        if (!video_vs) abort_run("end of frame");
        cap_clocks = n;
        cap_de = px;
    endtask

    task automatic check_frame(int k);
        for (int i = 0; i < FW*FH; i++) begin
            assert (frame[i] == expected_px(k, i)) else begin
                $display("mismatch video_rgb pixel %0d: got %h expected %h",
                         i, frame[i], expected_px(k, i));
                errors++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        bridge_addr_t rnd_addr;
        bridge_data_t rnd_val;
        bridge_data_t rd;
        int           last_k;
        int           k;
        void'($urandom(87056));
        reset_n = 1'b0;
        bridge_addr = '0;
        bridge_rd = 1'b0;
        bridge_wr = 1'b0;
        bridge_wr_data = '0;
        cont1_key = '0;
        // menu open keeps the accumulator still during register tests
        osnotify_inmenu = 1'b1;
        errors = 0;
        test_start = 0;
        tests_run = 0;
        tests_failed = 0;
        build_model();

        repeat (5) begin
            @(negedge clk_74a);
            expect_eq("video_de", video_de, 0);
            expect_eq("video_hs", video_hs, 0);
            expect_eq("video_vs", video_vs, 0);
            expect_eq("video_rgb", video_rgb, 0);
        end
        reset_n = 1'b1;
        end_test("reset outputs");

        bridge_read(GEN_SPEED_ADDR, rd);
        expect_eq("bridge_rd_data", rd, 32'd1);
        repeat (4) begin
            rnd_addr = $urandom;
            if (rnd_addr == GEN_SPEED_ADDR) rnd_addr = rnd_addr ^ 32'h4;
            bridge_read(rnd_addr, rd);
            expect_eq("bridge_rd_data", rd, 32'd0);
        end
        rnd_val = $urandom;
        bridge_write(GEN_SPEED_ADDR, rnd_val);
        bridge_read(GEN_SPEED_ADDR, rd);
        expect_eq("bridge_rd_data", rd, rnd_val);
        rnd_addr = $urandom;
        if (rnd_addr == GEN_SPEED_ADDR) rnd_addr = rnd_addr ^ 32'h4;
        bridge_write(rnd_addr, ~rnd_val);
        bridge_read(GEN_SPEED_ADDR, rd);
        expect_eq("bridge_rd_data", rd, rnd_val);
        bridge_write(GEN_SPEED_ADDR, 32'd0);
        osnotify_inmenu = 1'b0;
        end_test("speed register");

        capture_frame();
        expect_eq("clocks per frame", cap_clocks, 384);
        expect_eq("video_hs pulses", cap_hs, 16);
        expect_eq("video_de cycles", cap_de, 192);
        end_test("video timing");

        repeat (2) begin
            capture_frame();
            check_frame(0);
        end
        end_test("frozen seed");

        bridge_write(GEN_SPEED_ADDR, 32'd1);
        last_k = 0;
        prev_frame = frame;
        repeat (20) begin
            capture_frame();
            // a generation may change mid-frame, so only steady frames count
            if (frame_matches_prev()) begin
                k = find_gen(last_k, MAX_GEN);
                assert (k >= 0) else begin
                    $display("steady frame matches no generation from %0d on", last_k);
                    errors++;
                end
                if (k >= 0) last_k = k;
            end
            prev_frame = frame;
        end
        assert (last_k > 0) else begin
            $display("grid did not advance past the seed within 20 frames");
            errors++;
        end
        end_test("evolution");

        osnotify_inmenu = 1'b1;
        capture_frame();
        k = find_gen(last_k, last_k + 2);
        assert (k >= 0) else begin
            $display("paused frame matches no generation near %0d", last_k);
            errors++;
        end
        repeat (4) begin
            capture_frame();
            if (k >= 0) check_frame(k);
        end
        end_test("pause");

        bridge_write(GEN_SPEED_ADDR, 32'd0);
        osnotify_inmenu = 1'b0;
        @(negedge clk_74a);
        cont1_key[KEY_START] = 1'b1;
        @(negedge clk_74a);
        cont1_key[KEY_START] = 1'b0;
        capture_frame();
        check_frame(0);
        end_test("restart");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
